// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       := tb_i2c_init
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/cmd_output_regs.sv ====
// master command and data holding registers, cleared on acceptance
`default_nettype none

module cmd_output_regs (
    input  wire logic                               clk,
    input  wire logic                               rst,
    i2c_cmd_if.out                                  cmd,
    input  wire logic                               cmd_ready,
    input  wire logic                               data_tready,
    output logic [i2c_bus_pkg::addr_width-1:0]      cmd_address,
    output logic                                    cmd_start,
    output logic                                    cmd_write,
    output logic                                    cmd_stop,
    output logic                                    cmd_valid,
    output logic [i2c_bus_pkg::data_width-1:0]      data_tdata,
    output logic                                    data_tvalid
);

    logic cmd_accept;

    assign cmd_accept  = cmd_valid & cmd_ready;
    assign cmd.pending = cmd_valid | data_tvalid;

    // flags and valids
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_start   <= 1'b0;
            cmd_write   <= 1'b0;
            cmd_stop    <= 1'b0;
            cmd_valid   <= 1'b0;
            data_tvalid <= 1'b0;
        end else begin
            // start survives until the next accepted command
            cmd_start   <= (cmd_start & ~cmd_accept & ~cmd.issue_stop) | cmd.set_addr;
            cmd_write   <= (cmd_write & ~cmd_accept & ~cmd.issue_stop) | cmd.issue_write;
            cmd_stop    <= (cmd_stop & ~cmd_accept & ~cmd.issue_write) | cmd.issue_stop;
            cmd_valid   <= (cmd_valid & ~cmd_ready) | cmd.issue_write | cmd.issue_stop;
            // channels independent
            data_tvalid <= (data_tvalid & ~data_tready) | cmd.issue_write;
        end
    end

    // payload, only loaded by a pulse
    always_ff @(posedge clk) begin
        if (cmd.set_addr) begin
            cmd_address <= cmd.addr;
        end
        if (cmd.issue_write) begin
            data_tdata <= cmd.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i2c_bus_pkg.sv ====
// field widths of the I2C master command and data ports
`default_nettype none

package i2c_bus_pkg;

    // 7-bit device address
    localparam int addr_width = 7;

    // one data byte per write
    localparam int data_width = 8;

endpackage

`default_nettype wire

// ==== rtl/i2c_cmd_if.sv ====
// sequencer to output stage command pulses and pending status
`default_nettype none

interface i2c_cmd_if;

    // latch address, set start flag
    logic                               set_addr;
    logic [i2c_bus_pkg::addr_width-1:0] addr;

    // raise cmd valid with write, plus data valid
    logic                               issue_write;
    logic [i2c_bus_pkg::data_width-1:0] data;

    // raise cmd valid with stop
    logic                               issue_stop;

    // output regs still holding something
    logic                               pending;

    modport seq (
        output set_addr, addr, issue_write, data, issue_stop,
        input  pending
    );

    modport out (
        input  set_addr, addr, issue_write, data, issue_stop,
        output pending
    );

endinterface

`default_nettype wire

// ==== rtl/i2c_init.sv ====
// boot-time I2C configuration sequencer, top level
// ROM, delay, command FSM and master-port registers
`default_nettype none

module i2c_init #(
    parameter int delay_base = 16
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               start,
    input  wire logic                               cmd_ready,
    input  wire logic                               data_tready,
    output logic [i2c_bus_pkg::addr_width-1:0]      cmd_address,
    output logic                                    cmd_start,
    output logic                                    cmd_write,
    output logic                                    cmd_stop,
    output logic                                    cmd_valid,
    output logic [i2c_bus_pkg::data_width-1:0]      data_tdata,
    output logic                                    data_tvalid,
    output logic                                    busy
);

    logic [i2c_init_pkg::rom_addr_width-1:0] rom_addr;
    i2c_init_pkg::init_word_u                rom_word;
    logic                                    delay_load;
    logic [3:0]                              delay_exp;
    logic                                    delay_running;

    // pulses from FSM to output regs
    i2c_cmd_if cmd_bus ();

    init_rom u_rom (
        .clk  (clk),
        .rst  (rst),
        .addr (rom_addr),
        .word (rom_word)
    );

    init_delay #(
        .delay_base (delay_base)
    ) u_delay (
        .clk      (clk),
        .rst      (rst),
        .load     (delay_load),
        .exponent (delay_exp),
        .running  (delay_running)
    );

    init_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .word       (rom_word),
        .rom_addr   (rom_addr),
        .running    (delay_running),
        .delay_load (delay_load),
        .delay_exp  (delay_exp),
        .busy       (busy),
        .cmd        (cmd_bus.seq)
    );

    cmd_output_regs u_out (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd_bus.out),
        .cmd_ready   (cmd_ready),
        .data_tready (data_tready),
        .cmd_address (cmd_address),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_stop    (cmd_stop),
        .cmd_valid   (cmd_valid),
        .data_tdata  (data_tdata),
        .data_tvalid (data_tvalid)
    );

endmodule

`default_nettype wire

// ==== rtl/i2c_init_pkg.sv ====
// command set of the init sequencer
// ROM word layout, opcodes, FSM states and ROM geometry
`default_nettype none

package i2c_init_pkg;

    // data byte command: flag set, byte in the low bits
    typedef struct packed {
        logic                               flag;
        logic [i2c_bus_pkg::data_width-1:0] value;
    } data_cmd_t;

    // address command: 2-bit tag above a device address
    typedef struct packed {
        logic [1:0]                         tag;
        logic [i2c_bus_pkg::addr_width-1:0] addr;
    } addr_cmd_t;

    // one 9-bit ROM word, read either way
    typedef union packed {
        data_cmd_t data_cmd;
        addr_cmd_t addr_cmd;
    } init_word_u;

    // control opcodes, matched on the whole word
    localparam logic [8:0] op_stop       = 9'd0;
    localparam logic [8:0] op_exit_mode  = 9'd1;
    localparam logic [8:0] op_write_cur  = 9'd3;
    localparam logic [8:0] op_addr_block = 9'd8;
    localparam logic [8:0] op_data_block = 9'd9;
    localparam logic [8:0] op_send_stop  = 9'd65;

    // delay prefix, exponent in the low nibble
    localparam logic [4:0] delay_tag = 5'b00001;
    localparam logic [1:0] addr_tag  = 2'b01;

    typedef enum logic [2:0] {
        st_idle,
        st_run,
        st_find_addr_block,
        st_next_addr,
        st_data_block
    } seq_state_e;

    localparam int rom_len        = 17;
    localparam int rom_addr_width = 5;

endpackage

`default_nettype wire

// ==== rtl/init_delay.sv ====
// power-of-two delay counter
`default_nettype none

module init_delay #(
    parameter int delay_base = 16
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       load,
    input  wire logic [3:0] exponent,
    output logic            running
);

    logic [31:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            // 2^(base + d) cycles
            count <= 32'd1 << (delay_base + int'(exponent));
        end else if (count != '0) begin
            count <= count - 32'd1;
        end
    end

    // high from the cycle after load until count runs out
    assign running = (count != '0);

endmodule

`default_nettype wire

// ==== rtl/init_rom.sv ====
// configuration command ROM, registered read
`default_nettype none

module init_rom (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire logic [i2c_init_pkg::rom_addr_width-1:0] addr,
    output i2c_init_pkg::init_word_u                     word
);

    logic [8:0] rom_bits;

    // table contents
    always_comb begin
        case (addr)
            // single device: write 0x000411 to 0x50
            5'd0:    rom_bits = {i2c_init_pkg::addr_tag, 7'h50};
            5'd1:    rom_bits = {1'b1, 8'h00};
            5'd2:    rom_bits = {1'b1, 8'h04};
            5'd3:    rom_bits = {1'b1, 8'h11};
            5'd4:    rom_bits = {i2c_init_pkg::delay_tag, 4'd1};
            5'd5:    rom_bits = i2c_init_pkg::op_send_stop;
            // data block replayed per listed device
            5'd6:    rom_bits = i2c_init_pkg::op_data_block;
            5'd7:    rom_bits = i2c_init_pkg::op_write_cur;
            5'd8:    rom_bits = {1'b1, 8'hA5};
            5'd9:    rom_bits = {1'b1, 8'h5A};
            5'd10:   rom_bits = i2c_init_pkg::op_send_stop;
            5'd11:   rom_bits = i2c_init_pkg::op_addr_block;
            5'd12:   rom_bits = {i2c_init_pkg::addr_tag, 7'h50};
            5'd13:   rom_bits = {i2c_init_pkg::addr_tag, 7'h51};
            5'd14:   rom_bits = {i2c_init_pkg::addr_tag, 7'h52};
            5'd15:   rom_bits = i2c_init_pkg::op_exit_mode;
            // past the end reads as stop
            default: rom_bits = i2c_init_pkg::op_stop;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word <= '0;
        end else begin
            word <= rom_bits;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/init_sequencer.sv ====
// command decoder FSM with ROM pointer, block pointers and start latch
`default_nettype none

module init_sequencer (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire logic                                    start,
    input  wire i2c_init_pkg::init_word_u                word,
    output logic [i2c_init_pkg::rom_addr_width-1:0]      rom_addr,
    input  wire logic                                    running,
    output logic                                         delay_load,
    output logic [3:0]                                   delay_exp,
    output logic                                         busy,
    i2c_cmd_if.seq                                       cmd
);

    i2c_init_pkg::seq_state_e state, state_next;

    // current word pointer, plus saved block starts
    logic [i2c_init_pkg::rom_addr_width-1:0] ptr, ptr_next, ptr_inc;
    logic [i2c_init_pkg::rom_addr_width-1:0] addr_blk, addr_blk_next;
    logic [i2c_init_pkg::rom_addr_width-1:0] data_blk, data_blk_next;

    // device address used by write-current
    logic [i2c_bus_pkg::addr_width-1:0] cur_addr, cur_addr_next;

    logic start_flag, start_flag_next;
    logic stall;

    logic [8:0] word_bits;
    logic       is_data;
    logic       is_addr;
    logic       is_delay;
    logic       in_block;

    assign word_bits = word;
    assign is_data   = word.data_cmd.flag;
    assign is_addr   = (word.addr_cmd.tag == i2c_init_pkg::addr_tag);
    assign is_delay  = (word_bits[8:4] == i2c_init_pkg::delay_tag);
    assign delay_exp = word_bits[3:0];
    assign ptr_inc   = ptr + 1'b1;
    assign in_block  = (state == i2c_init_pkg::st_data_block);

    // hold while output regs busy or delay counting
    assign stall = cmd.pending | running;

    // next word fetched from the chosen pointer
    assign rom_addr = ptr_next;
    assign cmd.data = word.data_cmd.value;

    always_comb begin
        state_next      = state;
        ptr_next        = ptr;
        addr_blk_next   = addr_blk;
        data_blk_next   = data_blk;
        cur_addr_next   = cur_addr;
        start_flag_next = start_flag;
        cmd.set_addr    = 1'b0;
        cmd.addr        = word.addr_cmd.addr;
        cmd.issue_write = 1'b0;
        cmd.issue_stop  = 1'b0;
        delay_load      = 1'b0;

        if (!stall) begin
            case (state)
                i2c_init_pkg::st_idle: begin
                    // one run per rising start
                    if (!start_flag && start) begin
                        start_flag_next = 1'b1;
                        ptr_next        = '0;
                        state_next      = i2c_init_pkg::st_run;
                    end
                end
                i2c_init_pkg::st_run, i2c_init_pkg::st_data_block: begin
                    // most words just advance
                    ptr_next = ptr_inc;
                    if (is_data) begin
                        cmd.issue_write = 1'b1;
                    end else if (is_addr) begin
                        cmd.set_addr = 1'b1;
                    end else if (is_delay) begin
                        delay_load = 1'b1;
                    end else if (word_bits == i2c_init_pkg::op_send_stop) begin
                        cmd.issue_stop = 1'b1;
                    end else if (word_bits == i2c_init_pkg::op_data_block) begin
                        data_blk_next = ptr_inc;
                        state_next    = i2c_init_pkg::st_find_addr_block;
                    end else if (in_block && word_bits == i2c_init_pkg::op_write_cur) begin
                        // substitute the listed device
                        cmd.set_addr = 1'b1;
                        cmd.addr     = cur_addr;
                    end else if (in_block && word_bits == i2c_init_pkg::op_addr_block) begin
                        // back to the address list
                        ptr_next   = addr_blk;
                        state_next = i2c_init_pkg::st_next_addr;
                    end else if (in_block && word_bits == i2c_init_pkg::op_exit_mode) begin
                        state_next = i2c_init_pkg::st_run;
                    end else if (word_bits == i2c_init_pkg::op_stop) begin
                        cmd.issue_stop = 1'b1;
                        ptr_next       = ptr;
                        state_next     = i2c_init_pkg::st_idle;
                    end
                end
                i2c_init_pkg::st_find_addr_block: begin
                    // skip the data block on first pass
                    ptr_next = ptr_inc;
                    if (word_bits == i2c_init_pkg::op_addr_block) begin
                        addr_blk_next = ptr_inc;
                        state_next    = i2c_init_pkg::st_next_addr;
                    end else if (word_bits == i2c_init_pkg::op_data_block) begin
                        data_blk_next = ptr_inc;
                    end else if (word_bits == i2c_init_pkg::op_exit_mode) begin
                        state_next = i2c_init_pkg::st_run;
                    end else if (word_bits == i2c_init_pkg::op_stop) begin
                        cmd.issue_stop = 1'b1;
                        ptr_next       = ptr;
                        state_next     = i2c_init_pkg::st_idle;
                    end
                end
                i2c_init_pkg::st_next_addr: begin
                    ptr_next = ptr_inc;
                    if (is_addr) begin
                        // take this device, replay data block
                        cur_addr_next = word.addr_cmd.addr;
                        addr_blk_next = ptr_inc;
                        ptr_next      = data_blk;
                        state_next    = i2c_init_pkg::st_data_block;
                    end else if (word_bits == i2c_init_pkg::op_data_block) begin
                        data_blk_next = ptr_inc;
                        state_next    = i2c_init_pkg::st_find_addr_block;
                    end else if (word_bits == i2c_init_pkg::op_exit_mode) begin
                        state_next = i2c_init_pkg::st_run;
                    end else if (word_bits == i2c_init_pkg::op_stop) begin
                        cmd.issue_stop = 1'b1;
                        ptr_next       = ptr;
                        state_next     = i2c_init_pkg::st_idle;
                    end
                end
                default: begin
                    state_next = i2c_init_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= i2c_init_pkg::st_idle;
            ptr        <= '0;
            addr_blk   <= '0;
            data_blk   <= '0;
            cur_addr   <= '0;
            start_flag <= 1'b0;
            busy       <= 1'b0;
        end else begin
            state      <= state_next;
            ptr        <= ptr_next;
            addr_blk   <= addr_blk_next;
            data_blk   <= data_blk_next;
            cur_addr   <= cur_addr_next;
            // latch drops only once start goes low
            start_flag <= start & start_flag_next;
            // one cycle behind the FSM
            busy       <= (state != i2c_init_pkg::st_idle);
        end
    end

endmodule

`default_nettype wire

// ==== tests/i2c_init_assertions.sv ====
// master-port protocol assertions, bound into the top level
`default_nettype none

module i2c_init_assertions (
    input wire logic                               clk,
    input wire logic                               rst,
    input wire logic                               cmd_ready,
    input wire logic                               data_tready,
    input wire logic [i2c_bus_pkg::addr_width-1:0] cmd_address,
    input wire logic                               cmd_start,
    input wire logic                               cmd_write,
    input wire logic                               cmd_stop,
    input wire logic                               cmd_valid,
    input wire logic [i2c_bus_pkg::data_width-1:0] data_tdata,
    input wire logic                               data_tvalid
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_failures = 0;

    // stalled command keeps every field
    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=>
            cmd_valid && $stable({cmd_address, cmd_start, cmd_write, cmd_stop}))
        else begin
            assert_failures++;
            $error("command fields changed while cmd_ready was low");
        end

    // stalled data byte
    data_hold: assert property (@(posedge clk) disable iff (rst)
        data_tvalid && !data_tready |=> data_tvalid && $stable(data_tdata))
        else begin
            assert_failures++;
            $error("data byte changed while data_tready was low");
        end

    reset_quiet: assert property (@(posedge clk) rst |-> !cmd_valid)
        else begin
            assert_failures++;
            $error("cmd_valid high during reset");
        end

endmodule

bind i2c_init i2c_init_assertions u_protocol_checks (
    .clk         (clk),
    .rst         (rst),
    .cmd_ready   (cmd_ready),
    .data_tready (data_tready),
    .cmd_address (cmd_address),
    .cmd_start   (cmd_start),
    .cmd_write   (cmd_write),
    .cmd_stop    (cmd_stop),
    .cmd_valid   (cmd_valid),
    .data_tdata  (data_tdata),
    .data_tvalid (data_tvalid)
);

`default_nettype wire

// ==== tests/tb_i2c_init.sv ====
// testbench for the I2C init sequencer
// random-ready master model, expected command table and checks
`default_nettype none

module tb_i2c_init;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int delay_base     = 2;
    localparam int reset_cycles   = 5;
    localparam int run_count      = 2;
    localparam int cmd_count      = 14;
    // three config bytes, then two bytes per listed device
    localparam int write_count    = 9;
    localparam int delay_cycles   = 1 << (delay_base + 1);
    localparam int hold_cycles    = 40;
    localparam int cycles_per_cmd = 64;
    localparam int timeout_cycles = reset_cycles
        + run_count * (cmd_count * cycles_per_cmd + delay_cycles + hold_cycles);

    typedef struct packed {
        logic [i2c_bus_pkg::addr_width-1:0] addr;
        logic                               start;
        logic                               write;
        logic                               stop;
    } cmd_rec_t;

    logic                               clk;
    logic                               rst;
    logic                               start;
    logic                               cmd_ready;
    logic                               data_tready;
    logic [i2c_bus_pkg::addr_width-1:0] cmd_address;
    logic                               cmd_start;
    logic                               cmd_write;
    logic                               cmd_stop;
    logic                               cmd_valid;
    logic [i2c_bus_pkg::data_width-1:0] data_tdata;
    logic                               data_tvalid;
    logic                               busy;

    // expected commands, data byte only used on writes
    cmd_rec_t   exp_cmd [cmd_count];
    logic [7:0] exp_data [cmd_count];
    int         table_len;

    // what the master accepted
    cmd_rec_t   cmd_log [$];
    logic [7:0] data_log [$];
    int         accept_cycle [$];
    int         valid_cycle [$];
    logic       valid_seen = 1'b0;
    int         rise_cycle = 0;
    logic       busy_seen = 1'b0;

    int cycle = 0;
    int seed = 60;
    int value_errors = 0;
    int other_errors = 0;

    i2c_init #(
        .delay_base (delay_base)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cmd_ready   (cmd_ready),
        .data_tready (data_tready),
        .cmd_address (cmd_address),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_stop    (cmd_stop),
        .cmd_valid   (cmd_valid),
        .data_tdata  (data_tdata),
        .data_tvalid (data_tvalid),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // master ready lines, roughly 3 in 4 cycles
    initial begin
        cmd_ready   = 1'b0;
        data_tready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cmd_ready   = (($random(seed) & 3) != 0);
            data_tready = (($random(seed) & 3) != 0);
        end
    end

    // sampled mid-cycle, acceptance happens on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (busy) begin
                busy_seen = 1'b1;
            end
            if (cmd_valid && !valid_seen) begin
                valid_seen = 1'b1;
                rise_cycle = cycle;
            end
            if (cmd_valid && cmd_ready) begin
                cmd_log.push_back('{addr: cmd_address, start: cmd_start,
                                    write: cmd_write, stop: cmd_stop});
                accept_cycle.push_back(cycle);
                valid_cycle.push_back(rise_cycle);
                valid_seen = 1'b0;
            end
            if (data_tvalid && data_tready) begin
                data_log.push_back(data_tdata);
            end
        end
    end

    task automatic add_entry(input logic [6:0] address, input logic st, input logic wr,
                             input logic sp, input logic [7:0] data);
        exp_cmd[table_len]  = '{addr: address, start: st, write: wr, stop: sp};
        exp_data[table_len] = data;
        table_len++;
    endtask

    task automatic build_expected_table();
        logic [7:0] cfg_bytes [3];
        logic [6:0] devices [3];
        cfg_bytes = '{8'h00, 8'h04, 8'h11};
        devices   = '{7'h50, 7'h51, 7'h52};
        table_len = 0;
        // single device, start only on the first write
        for (int i = 0; i < 3; i++) begin
            add_entry(7'h50, (i == 0), 1'b1, 1'b0, cfg_bytes[i]);
        end
        add_entry(7'h50, 1'b0, 1'b0, 1'b1, 8'h00);
        // data block once per listed device
        foreach (devices[d]) begin
            add_entry(devices[d], 1'b1, 1'b1, 1'b0, 8'hA5);
            add_entry(devices[d], 1'b0, 1'b1, 1'b0, 8'h5A);
            add_entry(devices[d], 1'b0, 1'b0, 1'b1, 8'h00);
        end
        // final stop, address left at last device
        add_entry(7'h52, 1'b0, 1'b0, 1'b1, 8'h00);
    endtask

    task automatic compare_field(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // DUT outputs settle after the edge, log writes happen at negedge
    task automatic wait_sample();
        @(negedge clk);
        #1;
    endtask

    task automatic check_idle_outputs();
        wait_sample();
        compare_field("cmd_valid", 8'd0, cmd_valid);
        compare_field("data_tvalid", 8'd0, data_tvalid);
        compare_field("busy", 8'd0, busy);
        compare_field("cmd_start", 8'd0, cmd_start);
        compare_field("cmd_write", 8'd0, cmd_write);
        compare_field("cmd_stop", 8'd0, cmd_stop);
    endtask

    task automatic check_run_log(input int run);
        int d;
        d = 0;
        assert (cmd_log.size() == table_len) else begin
            other_errors++;
            $display("run %0d: master took %0d commands, expected %0d",
                     run, cmd_log.size(), table_len);
        end
        assert (data_log.size() == write_count) else begin
            other_errors++;
            $display("run %0d: master took %0d data bytes, expected %0d",
                     run, data_log.size(), write_count);
        end
        for (int i = 0; i < table_len && i < cmd_log.size(); i++) begin
            compare_field($sformatf("cmd_address[%0d]", i), exp_cmd[i].addr, cmd_log[i].addr);
            compare_field($sformatf("cmd_start[%0d]", i), exp_cmd[i].start, cmd_log[i].start);
            compare_field($sformatf("cmd_write[%0d]", i), exp_cmd[i].write, cmd_log[i].write);
            compare_field($sformatf("cmd_stop[%0d]", i), exp_cmd[i].stop, cmd_log[i].stop);
            if (exp_cmd[i].write && d < data_log.size()) begin
                compare_field($sformatf("data_tdata[%0d]", i), exp_data[i], data_log[d]);
                d++;
            end
        end
        // delay sits between the third write and the first stop
        if (cmd_log.size() > 3) begin
            assert (valid_cycle[3] - accept_cycle[2] >= delay_cycles) else begin
                other_errors++;
                $display("run %0d: first stop came %0d cycles after the last write, min %0d",
                         run, valid_cycle[3] - accept_cycle[2], delay_cycles);
            end
        end
        assert (busy_seen) else begin
            other_errors++;
            $display("run %0d: busy never went high", run);
        end
    endtask

    task automatic run_sequence(input int run);
        cmd_log.delete();
        data_log.delete();
        accept_cycle.delete();
        valid_cycle.delete();
        busy_seen = 1'b0;
        @(posedge clk);
        #1 start = 1'b1;
        // done once every command is taken and busy has dropped
        do begin
            wait_sample();
        end while (cmd_log.size() < table_len || data_log.size() < write_count || busy);
        // start still high, nothing may restart
        repeat (hold_cycles) begin
            wait_sample();
            assert (!busy && !cmd_valid) else begin
                other_errors++;
                $display("run %0d: sequence restarted while start stayed high", run);
            end
        end
        @(posedge clk);
        #1 start = 1'b0;
        repeat (4) @(posedge clk);
        check_run_log(run);
    endtask

    task automatic finish_with_report();
        int protocol_errors;
        protocol_errors = uut.u_protocol_checks.assert_failures;
        $display("errors: %0d value, %0d other, %0d protocol",
                 value_errors, other_errors, protocol_errors);
        if (value_errors == 0 && other_errors == 0 && protocol_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        build_expected_table();
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
        check_idle_outputs();
        for (int run = 1; run <= run_count; run++) begin
            run_sequence(run);
        end
        finish_with_report();
    end

    // watchdog
    initial begin
        wait (cycle >= timeout_cycles);
        other_errors++;
        $display("timeout: sequence did not finish within %0d cycles", timeout_cycles);
        finish_with_report();
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/i2c_bus_pkg.sv
rtl/i2c_init_pkg.sv
rtl/i2c_cmd_if.sv
rtl/init_rom.sv
rtl/init_delay.sv
rtl/init_sequencer.sv
rtl/cmd_output_regs.sv
rtl/i2c_init.sv
tests/i2c_init_assertions.sv
tests/tb_i2c_init.sv
